/* project.f */
+incdir+tests
source/la_regs_pkg.sv
source/la_capture_pkg.sv
source/la_control_if.sv
source/la_reg_bank.sv
source/la_trigger.sv
source/la_channel_select.sv
source/la_capture_buffer.sv
source/la_top.sv
tests/la_tb.sv

/* tests/la_tb_tasks.svh */
task automatic end_with_failure();
   $display("Checks failed");
   $fatal(1);
endtask

// Inputs change 1 ns after the rising edge
task automatic next_cycle();
   @(posedge observer_clk);
   #1;
endtask

task automatic reg_write_byte(input la_reg_addr_t addr, input la_reg_byte_t data);
   reg_address = addr;
   reg_bytecnt = '0;
   reg_datai   = data;
   reg_write   = 1'b1;
   next_cycle();
   reg_write   = 1'b0;
endtask

// One cycle per read, data taken at the falling edge
task automatic reg_read_byte(input la_reg_addr_t addr, input la_bytecnt_t index,
                             output la_reg_byte_t data);
   reg_address = addr;
   reg_bytecnt = index;
   reg_read    = 1'b1;
   @(negedge observer_clk);
   data = reg_datao;
   next_cycle();
   reg_read = 1'b0;
endtask

task automatic compare_byte(input string test, input la_reg_byte_t expected,
                            input la_reg_byte_t actual);
   if (actual !== expected) begin
      $display("Error %s expected %h actual %h", test, expected, actual);
      end_with_failure();
   end
endtask

task automatic compare_record(input string test, input la_capture_t expected,
                              input la_capture_t actual);
   if (actual !== expected) begin
      $display("Error %s expected %h actual %h", test, expected, actual);
      end_with_failure();
   end
endtask

task automatic check_reg(input string test, input la_reg_addr_t addr,
                         input la_bytecnt_t index, input la_reg_byte_t expected);
   la_reg_byte_t actual;
   reg_read_byte(addr, index, actual);
   compare_byte(test, expected, actual);
endtask

task automatic check_channel(input string test, input la_read_sel_t sel,
                             input la_capture_t expected);
   la_capture_t  actual;
   la_reg_byte_t data;
   reg_write_byte(la_addr_read_select, la_reg_byte_t'(sel));
   next_cycle();  // Read mux is registered
   for (int b = 0; b < record_bytes; b++) begin
      reg_read_byte(la_addr_read_select, la_bytecnt_t'(b), data);
      actual[b*la_reg_width +: la_reg_width] = data;
   end
   compare_record(test, expected, actual);
endtask

task automatic check_all_channels(input string test);
   for (int ch = 0; ch < la_channel_count; ch++) begin
      check_channel($sformatf("%s channel %0d", test, ch), la_read_sel_t'(ch),
                    expected_records[ch]);
   end
endtask

// Only the selected group carries the word
task automatic drive_group(input la_group_t group, input la_channels_t word);
   glitch_probes = (group == 2'd0) ? word[7:0] : '0;
   io_probes     = (group == 2'd1) ? word : '0;
   userio_probes = (group == 2'd2) ? word : '0;
   debug_probes  = (group == 2'd3) ? word : '0;
endtask

task automatic wait_capture_done();
   la_reg_byte_t status;
   for (int n = 0; n < 16; n++) begin
      reg_read_byte(la_addr_status, '0, status);
      if (status == 8'h00) return;
   end
   $display("Capture still running long after its last sample was due");
   end_with_failure();
endtask

// Word k goes out k cycles after the trigger rises and is stored as sample k-1
task automatic capture_random(input la_group_t group, input la_trigger_sel_t code,
                              input int trig_bit);
   la_channels_t word;
   la_channels_t sample;
   drive_group(group, '0);
   reg_write_byte(la_addr_capture_group, la_reg_byte_t'(group));
   reg_write_byte(la_addr_trigger_source, la_reg_byte_t'(code));
   repeat (4) next_cycle();  // Synchronizer settles low
   for (int k = 0; k <= la_capture_depth; k++) begin
      word = la_channels_t'($urandom);
      word[trig_bit] = 1'b1;  // Trigger held high, no restart
      drive_group(group, word);
      sample = (group == 2'd0) ? {1'b0, word[7:0]} : word;
      if (k > 0) begin
         for (int ch = 0; ch < la_channel_count; ch++) begin
            expected_records[ch][k-1] = sample[ch];
         end
      end
      next_cycle();
   end
   drive_group(group, '0);
   wait_capture_done();
endtask

task automatic check_reset_values();
   check_reg("reset identity low", la_addr_exists, 0, 8'h41);
   check_reg("reset identity high", la_addr_exists, 1, 8'h4c);
   check_reg("reset identity past end", la_addr_exists, 2, 8'h00);
   check_reg("reset depth low", la_addr_capture_depth, 0, la_reg_byte_t'(la_capture_depth));
   check_reg("reset depth high", la_addr_capture_depth, 1,
             la_reg_byte_t'(la_capture_depth >> 8));
   check_reg("reset status", la_addr_status, 0, 8'h00);
   check_reg("reset capture group", la_addr_capture_group, 0, 8'h00);
   check_reg("reset trigger source", la_addr_trigger_source, 0, 8'h00);
   check_reg("reset read select", la_addr_read_select, 0, 8'h00);
   reg_address = la_addr_exists;
   @(negedge observer_clk);
   compare_byte("idle read port", 8'h00, reg_datao);  // reg_read is low
   next_cycle();
endtask

task automatic check_register_round_trip();
   la_reg_byte_t value;
   for (int n = 0; n < 4; n++) begin
      value = la_reg_byte_t'($urandom);
      reg_write_byte(la_addr_capture_group, value);
      check_reg("capture group round trip", la_addr_capture_group, 0, value & 8'h03);
      value = la_reg_byte_t'($urandom);
      reg_write_byte(la_addr_trigger_source, value);
      check_reg("trigger source round trip", la_addr_trigger_source, 0, value & 8'h07);
   end
   check_reg("capture group byte 1", la_addr_capture_group, 1, 8'h00);
   // Read select shows through the record it names, all records still empty
   reg_write_byte(la_addr_read_select, 8'hfc);  // Masks to 12
   next_cycle();
   check_reg("read select round trip", la_addr_read_select, 0, 8'hfc);
   check_reg("read select round trip", la_addr_read_select, 2, 8'h03);
   reg_write_byte(la_addr_read_select, 8'h37);  // Masks to channel 7
   next_cycle();
   check_reg("read select round trip", la_addr_read_select, 0, 8'h00);
   check_reg("read select round trip", la_addr_read_select, 2, 8'h00);
endtask

task automatic check_random_capture();
   reg_write_byte(la_addr_read_select, 8'd4);
   capture_random(2'd1, 3'd3, 4);  // io group, hs1 trigger
   check_all_channels("random capture");
endtask

task automatic check_capture_status();
   la_reg_byte_t status;
   drive_group(2'd1, '0);
   reg_write_byte(la_addr_capture_group, 8'd1);
   reg_write_byte(la_addr_trigger_source, 8'd3);
   repeat (4) next_cycle();
   io_probes = 9'h010;  // hs1 rises and stays high
   // Read k falls k cycles after the rise, capturing spans reads 3 to depth+1
   for (int k = 0; k <= la_capture_depth + 3; k++) begin
      reg_read_byte(la_addr_status, '0, status);
      compare_byte($sformatf("status %0d cycles after trigger", k),
                   (k >= 3 && k <= la_capture_depth + 1) ? 8'h01 : 8'h00, status);
   end
   for (int ch = 0; ch < la_channel_count; ch++) begin
      expected_records[ch] = {la_capture_depth{ch == 4}};
   end
   io_probes = '0;
   reg_write_byte(la_addr_trigger_source, 8'd6);  // No trigger source
   for (int k = 0; k < 16; k++) begin
      io_probes = (k % 4 < 2) ? 9'h1ff : 9'h000;
      reg_read_byte(la_addr_status, '0, status);
      compare_byte("status with trigger disabled", 8'h00, status);
   end
   io_probes = '0;
   check_all_channels("constant capture");
endtask

task automatic check_groups_and_unused();
   capture_random(2'd0, 3'd2, 7);  // Glitch trigger on bit 7
   check_all_channels("glitch group");
   capture_random(2'd3, 3'd4, 0);  // Debug bit 0
   check_all_channels("debug group");
   check_channel("unused read select", 4'd12, la_capture_t'(18'h3fffc));  // Ones in bits 2 to 17
endtask

/* tests/la_tb.sv */
`timescale 1ns/100ps

module la_tb;
   import la_regs_pkg::*;
   import la_capture_pkg::*;

   localparam int record_bytes = la_capture_depth / la_reg_width;
   // Four captures and 37 record reads, doubled for margin
   localparam int timeout_cycles = 2 * (4 * (la_capture_depth + 10) + 37 * (record_bytes + 3));

   logic         observer_clk;
   logic         reset;
   la_reg_addr_t reg_address;
   la_bytecnt_t  reg_bytecnt;
   la_reg_byte_t reg_datai;
   logic         reg_read;
   logic         reg_write;
   la_reg_byte_t reg_datao;
   la_glitch_t   glitch_probes;
   la_channels_t io_probes;
   la_channels_t userio_probes;
   la_channels_t debug_probes;

   la_capture_t  expected_records [la_channel_count];  // Model of the nine records
   int           cycle_count = 0;

   `include "la_tb_tasks.svh"

   la_top u_la_top (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .reg_address   (reg_address),
      .reg_bytecnt   (reg_bytecnt),
      .reg_datai     (reg_datai),
      .reg_read      (reg_read),
      .reg_write     (reg_write),
      .reg_datao     (reg_datao),
      .glitch_probes (glitch_probes),
      .io_probes     (io_probes),
      .userio_probes (userio_probes),
      .debug_probes  (debug_probes)
   );

   initial begin
      observer_clk = 1'b0;
      forever #5 observer_clk = ~observer_clk;
   end

   // Run limit
   always @(posedge observer_clk) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         $display("Timeout, the tests did not finish within %0d cycles", timeout_cycles);
         end_with_failure();
      end
   end

   initial begin
      void'($urandom(32'h8ae527de));
      reset         = 1'b1;
      reg_address   = '0;
      reg_bytecnt   = '0;
      reg_datai     = '0;
      reg_read      = 1'b0;
      reg_write     = 1'b0;
      glitch_probes = '0;
      io_probes     = '0;
      userio_probes = '0;
      debug_probes  = '0;
      repeat (3) @(posedge observer_clk);
      #1;
      reset = 1'b0;

      check_reset_values();
      check_register_round_trip();
      check_random_capture();
      check_capture_status();
      check_groups_and_unused();

      $display("All checks passed");
      $finish;
   end

endmodule

/* source/la_top.sv */
`timescale 1ns/100ps

module la_top (
   input  logic                         observer_clk,
   input  logic                         reset,

   // Register port
   input  la_regs_pkg::la_reg_addr_t    reg_address,
   input  la_regs_pkg::la_bytecnt_t     reg_bytecnt,
   input  la_regs_pkg::la_reg_byte_t    reg_datai,
   input  logic                         reg_read,
   input  logic                         reg_write,
   output la_regs_pkg::la_reg_byte_t    reg_datao,

   // Probe groups
   input  la_capture_pkg::la_glitch_t   glitch_probes,
   input  la_capture_pkg::la_channels_t io_probes,
   input  la_capture_pkg::la_channels_t userio_probes,
   input  la_capture_pkg::la_channels_t debug_probes
);
   import la_capture_pkg::*;

   logic         capture_go;
   la_channels_t samples;

   la_control_if ctrl ();  // Configuration and readout

   la_reg_bank u_reg_bank (
      .observer_clk (observer_clk),
      .reset        (reset),
      .reg_address  (reg_address),
      .reg_bytecnt  (reg_bytecnt),
      .reg_datai    (reg_datai),
      .reg_read     (reg_read),
      .reg_write    (reg_write),
      .reg_datao    (reg_datao),
      .ctrl         (ctrl)
   );

   la_trigger u_trigger (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .glitch_probes (glitch_probes),
      .io_probes     (io_probes),
      .debug_probes  (debug_probes),
      .capture_go    (capture_go),
      .ctrl          (ctrl)
   );

   la_channel_select u_channel_select (
      .observer_clk  (observer_clk),
      .glitch_probes (glitch_probes),
      .io_probes     (io_probes),
      .userio_probes (userio_probes),
      .debug_probes  (debug_probes),
      .samples       (samples),
      .ctrl          (ctrl)
   );

   la_capture_buffer u_capture_buffer (
      .observer_clk (observer_clk),
      .reset        (reset),
      .capture_go   (capture_go),
      .samples      (samples),
      .ctrl         (ctrl)
   );

endmodule

/* source/la_capture_buffer.sv */
`timescale 1ns/100ps

module la_capture_buffer (
   input  logic                         observer_clk,
   input  logic                         reset,
   input  logic                         capture_go,
   input  la_capture_pkg::la_channels_t samples,
   la_control_if.buffer                 ctrl
);
   import la_capture_pkg::*;

   la_capture_t records [la_channel_count];  // One shift register per channel
   la_count_t   sample_count;                // Samples stored so far

   // Capture records
   // A new sample always enters at the top and older ones move down
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         ctrl.capturing <= 1'b0;
         sample_count   <= '0;
         for (int ch = 0; ch < la_channel_count; ch++) begin
            records[ch] <= '0;
         end
      end else if (capture_go) begin
         // Start or restart, sample 0 goes to the top
         ctrl.capturing <= 1'b1;
         sample_count   <= la_count_t'(1);
         for (int ch = 0; ch < la_channel_count; ch++) begin
            records[ch] <= {samples[ch], {(la_capture_depth-1){1'b0}}};
         end
      end else if (ctrl.capturing) begin
         for (int ch = 0; ch < la_channel_count; ch++) begin
            records[ch] <= {samples[ch], records[ch][la_capture_depth-1:1]};
         end
         if (sample_count == la_count_t'(la_capture_depth - 1)) begin
            ctrl.capturing <= 1'b0;  // Last sample lands this cycle
         end else begin
            sample_count <= sample_count + 1'b1;
         end
      end
   end

   // Read channel mux
   always_ff @(posedge observer_clk) begin
      if (ctrl.read_select < la_read_sel_t'(la_channel_count)) begin
         ctrl.observer_data <= records[ctrl.read_select];
      end else begin
         ctrl.observer_data <= la_unused_pattern;  // No such channel
      end
   end

endmodule

/* source/la_channel_select.sv */
`timescale 1ns/100ps

module la_channel_select (
   input  logic                         observer_clk,
   input  la_capture_pkg::la_glitch_t   glitch_probes,
   input  la_capture_pkg::la_channels_t io_probes,
   input  la_capture_pkg::la_channels_t userio_probes,
   input  la_capture_pkg::la_channels_t debug_probes,
   output la_capture_pkg::la_channels_t samples,  // Registered group, one cycle late
   la_control_if.select                 ctrl
);
   import la_capture_pkg::*;

   la_channels_t group_probes;

   // Pick the nine probes of the active group
   always_comb begin
      unique case (ctrl.capture_group)
         la_group_glitch: begin
            group_probes = {1'b0, glitch_probes};  // Channel 8 unused here
         end
         la_group_io: begin
            group_probes = io_probes;
         end
         la_group_userio: begin
            group_probes = userio_probes;
         end
         la_group_debug: begin
            group_probes = debug_probes;
         end
      endcase
   end

   // Sampling flop in front of the capture records
   always_ff @(posedge observer_clk) begin
      samples <= group_probes;
   end

endmodule

/* source/la_trigger.sv */
`timescale 1ns/100ps

module la_trigger (
   input  logic                         observer_clk,
   input  logic                         reset,
   input  la_capture_pkg::la_glitch_t   glitch_probes,
   input  la_capture_pkg::la_channels_t io_probes,
   input  la_capture_pkg::la_channels_t debug_probes,
   output logic                         capture_go,  // One cycle per rising trigger
   la_control_if.trigger                ctrl
);
   import la_capture_pkg::*;

   logic       trigger_raw;
   logic [1:0] trigger_sync;  // Bit 1 is the synchronized level
   logic       trigger_last;

   // Source select
   always_comb begin
      case (ctrl.trigger_source)
         la_trig_adc_go:    trigger_raw = glitch_probes[la_glitch_adc_go_bit];
         la_trig_glitch_go: trigger_raw = glitch_probes[la_glitch_go_bit];
         la_trig_glitch:    trigger_raw = glitch_probes[la_glitch_trig_bit];
         la_trig_hs1:       trigger_raw = io_probes[la_io_hs1_bit];
         la_trig_debug:     trigger_raw = debug_probes[la_debug_trig_bit];
         default:           trigger_raw = 1'b0;  // Trigger disabled
      endcase
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trigger_sync <= '0;
         trigger_last <= 1'b0;
      end else begin
         trigger_sync <= {trigger_sync[0], trigger_raw};
         trigger_last <= trigger_sync[1];
      end
   end

   // Rising edge of the synchronized level
   assign capture_go = trigger_sync[1] & ~trigger_last;

endmodule

/* source/la_reg_bank.sv */
`timescale 1ns/100ps

module la_reg_bank (
   input  logic                      observer_clk,
   input  logic                      reset,
   input  la_regs_pkg::la_reg_addr_t reg_address,
   input  la_regs_pkg::la_bytecnt_t  reg_bytecnt,  // Byte of a multi-byte register
   input  la_regs_pkg::la_reg_byte_t reg_datai,
   input  logic                      reg_read,
   input  logic                      reg_write,
   output la_regs_pkg::la_reg_byte_t reg_datao,
   la_control_if.regs                ctrl
);
   import la_regs_pkg::*;
   import la_capture_pkg::*;

   logic first_byte;  // Single-byte registers only answer on byte 0

   // One byte of a 16-bit readback value, zero past its end
   function automatic la_reg_byte_t wide_byte(
      input la_wide_reg_t value,
      input la_bytecnt_t  index
   );
      la_reg_byte_t result;
      result = '0;
      if (index < la_bytecnt_t'(la_wide_bytes)) begin
         result = value[index*la_reg_width +: la_reg_width];
      end
      return result;
   endfunction

   assign first_byte = (reg_bytecnt == '0);

   // Configuration registers
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         ctrl.capture_group  <= '0;
         ctrl.trigger_source <= '0;
         ctrl.read_select    <= '0;
      end else if (reg_write) begin
         case (reg_address)
            la_addr_capture_group: begin
               ctrl.capture_group <= reg_datai[$bits(la_group_t)-1:0];
            end
            la_addr_trigger_source: begin
               ctrl.trigger_source <= reg_datai[$bits(la_trigger_sel_t)-1:0];
            end
            la_addr_read_select: begin
               ctrl.read_select <= reg_datai[$bits(la_read_sel_t)-1:0];
            end
            default: begin
               // Read-only or unmapped, write ignored
            end
         endcase
      end
   end

   // Readback, combinational and idle-low
   always_comb begin
      reg_datao = '0;
      if (reg_read) begin
         case (reg_address)
            la_addr_exists: begin
               reg_datao = wide_byte(la_exists_code, reg_bytecnt);
            end
            la_addr_capture_depth: begin
               reg_datao = wide_byte(la_wide_reg_t'(la_capture_depth), reg_bytecnt);
            end
            la_addr_status: begin
               if (first_byte) reg_datao[la_status_capturing_bit] = ctrl.capturing;
            end
            la_addr_capture_group: begin
               if (first_byte) reg_datao = la_reg_byte_t'(ctrl.capture_group);
            end
            la_addr_trigger_source: begin
               if (first_byte) reg_datao = la_reg_byte_t'(ctrl.trigger_source);
            end
            la_addr_read_select: begin
               // 128 bytes cover the whole record
               reg_datao = ctrl.observer_data[reg_bytecnt*la_reg_width +: la_reg_width];
            end
            default: begin
               reg_datao = '0;
            end
         endcase
      end
   end

endmodule

/* source/la_control_if.sv */
`timescale 1ns/100ps

interface la_control_if;
   import la_capture_pkg::*;

   la_group_t       capture_group;  // Probe group feeding the channels
   la_trigger_sel_t trigger_source;
   la_read_sel_t    read_select;    // Channel shown on observer_data
   logic            capturing;
   la_capture_t     observer_data;

   // Register bank owns the configuration
   modport regs (
      output capture_group,
      output trigger_source,
      output read_select,
      input  capturing,
      input  observer_data
   );

   modport trigger (
      input  trigger_source
   );

   modport select (
      input  capture_group
   );

   // Capture side reports status and the selected record
   modport buffer (
      input  read_select,
      output capturing,
      output observer_data
   );

endinterface

/* source/la_capture_pkg.sv */
package la_capture_pkg;

   localparam int la_capture_depth = 1024; // Samples per channel
   localparam int la_channel_count = 9;
   localparam int la_glitch_count  = 8;    // Glitch group has no ninth probe
   localparam int la_count_width   = $clog2(la_capture_depth);

   typedef logic [la_capture_depth-1:0] la_capture_t;  // Bit i is sample i
   typedef logic [la_channel_count-1:0] la_channels_t;
   typedef logic [la_glitch_count-1:0]  la_glitch_t;
   typedef logic [la_count_width-1:0]   la_count_t;
   typedef logic [1:0]                  la_group_t;
   typedef logic [2:0]                  la_trigger_sel_t;
   typedef logic [3:0]                  la_read_sel_t;

   // Capture groups
   localparam la_group_t la_group_glitch = 2'd0;
   localparam la_group_t la_group_io     = 2'd1;
   localparam la_group_t la_group_userio = 2'd2;
   localparam la_group_t la_group_debug  = 2'd3;

   // Trigger sources, codes 5 to 7 never fire
   localparam la_trigger_sel_t la_trig_adc_go    = 3'd0;
   localparam la_trigger_sel_t la_trig_glitch_go = 3'd1;
   localparam la_trigger_sel_t la_trig_glitch    = 3'd2;
   localparam la_trigger_sel_t la_trig_hs1       = 3'd3;
   localparam la_trigger_sel_t la_trig_debug     = 3'd4;

   // Probe bit positions of the trigger candidates
   localparam int la_glitch_adc_go_bit = 5;
   localparam int la_glitch_go_bit     = 4;
   localparam int la_glitch_trig_bit   = 7;
   localparam int la_io_hs1_bit        = 4;
   localparam int la_debug_trig_bit    = 0;

   // Returned for read selects past the last channel
   localparam la_capture_t la_unused_pattern = la_capture_t'({16'hffff, 2'b00});

endpackage

/* source/la_regs_pkg.sv */
package la_regs_pkg;

   // Register port geometry
   localparam int la_addr_width    = 8;
   localparam int la_reg_width     = 8;
   localparam int la_bytecnt_width = 7;

   // Multi-byte readback registers (identity and depth)
   localparam int la_wide_width = 16;
   localparam int la_wide_bytes = la_wide_width / la_reg_width;

   typedef logic [la_addr_width-1:0]    la_reg_addr_t;
   typedef logic [la_reg_width-1:0]     la_reg_byte_t;
   typedef logic [la_bytecnt_width-1:0] la_bytecnt_t;
   typedef logic [la_wide_width-1:0]    la_wide_reg_t;

   // Register map
   localparam la_reg_addr_t la_addr_exists         = 8'd0;
   localparam la_reg_addr_t la_addr_capture_depth  = 8'd1;
   localparam la_reg_addr_t la_addr_status         = 8'd2;
   localparam la_reg_addr_t la_addr_capture_group  = 8'd3;
   localparam la_reg_addr_t la_addr_trigger_source = 8'd4;
   localparam la_reg_addr_t la_addr_read_select    = 8'd5;

   localparam la_wide_reg_t la_exists_code = 16'h4c41; // "LA", low byte first

   localparam int la_status_capturing_bit = 0;

endpackage
